//--- hdl/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// issue and broadcast width
`define N 2

// reservation station
`define RS_SZ        8
`define RS_CNT_WIDTH 4

// functional units
`define NUM_FU_ALU  2
`define NUM_FU_MULT 1

// tags and data
`define PRN_WIDTH  6
`define ROBN_WIDTH 5
`define XLEN       32

`endif

//--- hdl/isa_pkg.sv
package isa_pkg;

    // unit class of an instruction
    typedef enum logic [0:0] {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_func_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate

    localparam logic [2:0] F3_ADD = 3'b000; // also SUB and MUL
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001; // M extension

endpackage

//--- hdl/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;
    import isa_pkg::*;

    // ready bit of the owner picks the live view
    typedef union packed {
        logic [`XLEN-1:0] value;
        struct packed {
            logic [`XLEN-`PRN_WIDTH-1:0] pad;
            logic [`PRN_WIDTH-1:0]       prn;
        } tag;
    } operand_u;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            inst;
        logic                   src1_ready;
        operand_u               src1;
        logic                   src2_ready;
        operand_u               src2;
        logic [`PRN_WIDTH-1:0]  dest_prn;
        logic [`ROBN_WIDTH-1:0] robn;
    } dispatch_slot_t;

    typedef struct packed {
        logic                   valid;
        fu_type_e               fu;
        alu_func_e              func;
        logic                   op1_ready;
        operand_u               op1;
        logic                   op2_ready;
        operand_u               op2;
        logic [`PRN_WIDTH-1:0]  dest_prn;
        logic [`ROBN_WIDTH-1:0] robn;
    } rs_entry_t;

    // operands are plain values by the time they reach a unit
    typedef struct packed {
        logic                   valid;
        alu_func_e              func;
        logic [`XLEN-1:0]       op1;
        logic [`XLEN-1:0]       op2;
        logic [`PRN_WIDTH-1:0]  dest_prn;
        logic [`ROBN_WIDTH-1:0] robn;
    } fu_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [`PRN_WIDTH-1:0]  dest_prn;
        logic [`XLEN-1:0]       value;
        logic [`ROBN_WIDTH-1:0] robn;
    } cdb_packet_t;

endpackage

//--- hdl/inst_decode.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module inst_decode import isa_pkg::*, ooo_pkg::*; (
    input  dispatch_slot_t [`N-1:0] slots,
    output rs_entry_t      [`N-1:0] entries
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm;
    logic             known; // instruction is in the supported set

    always_comb begin
        for (int i = 0; i < `N; i++) begin
            opcode = slots[i].inst[6:0];
            funct3 = slots[i].inst[14:12];
            funct7 = slots[i].inst[31:25];
            imm    = {{(`XLEN-12){slots[i].inst[31]}}, slots[i].inst[31:20]};
            known  = 1'b0;

            entries[i].fu        = FU_ALU;
            entries[i].func      = ALU_ADD;
            entries[i].op1_ready = slots[i].src1_ready;
            entries[i].op1       = slots[i].src1;
            entries[i].op2_ready = slots[i].src2_ready;
            entries[i].op2       = slots[i].src2;
            entries[i].dest_prn  = slots[i].dest_prn;
            entries[i].robn      = slots[i].robn;

            if (opcode == OPC_OP) begin
                if (funct7 == F7_MULDIV && funct3 == F3_ADD) begin
                    entries[i].fu = FU_MULT; // MUL, low word
                    known = 1'b1;
                end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    entries[i].func = ALU_SUB;
                    known = 1'b1;
                end else if (funct7 == F7_BASE) begin
                    known = 1'b1;
                    case (funct3)
                        F3_ADD:  entries[i].func = ALU_ADD;
                        F3_SLL:  entries[i].func = ALU_SLL;
                        F3_SLT:  entries[i].func = ALU_SLT;
                        F3_XOR:  entries[i].func = ALU_XOR;
                        F3_SRL:  entries[i].func = ALU_SRL;
                        F3_OR:   entries[i].func = ALU_OR;
                        F3_AND:  entries[i].func = ALU_AND;
                        default: known = 1'b0; // SLTU
                    endcase
                end
            end else if (opcode == OPC_OP_IMM) begin
                // immediate takes the place of source 2
                entries[i].op2_ready = 1'b1;
                entries[i].op2.value = imm;
                known = 1'b1;
                case (funct3)
                    F3_ADD:  entries[i].func = ALU_ADD;
                    F3_SLT:  entries[i].func = ALU_SLT;
                    F3_XOR:  entries[i].func = ALU_XOR;
                    F3_OR:   entries[i].func = ALU_OR;
                    F3_AND:  entries[i].func = ALU_AND;
                    default: known = 1'b0; // shifts by immediate not handled
                endcase
            end

            entries[i].valid = slots[i].valid && known;
        end
    end

endmodule

//--- hdl/rs_select.sv
`timescale 1ns/1ps

module rs_select #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
)(
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    logic [WIDTH-1:0] remaining;
    logic [WIDTH-1:0] seen;     // bits granted so far
    logic             overlap;

    always_comb begin
        remaining = req;
        for (int k = 0; k < REQS; k++) begin
            gnt_bus[k] = remaining & (~remaining + 1'b1); // lowest set bit
            remaining  = remaining & ~gnt_bus[k];
        end
    end

    always_comb begin
        seen    = '0;
        overlap = 1'b0;
        for (int k = 0; k < REQS; k++) begin
            overlap = overlap | (|(seen & gnt_bus[k]));
            seen    = seen | gnt_bus[k];
        end
        assert final (!overlap);
    end

endmodule

//--- hdl/rs.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module rs import isa_pkg::*, ooo_pkg::*; (
    input  logic                               clock,
    input  logic                               reset,
    input  rs_entry_t   [`N-1:0]               entries_in,
    input  cdb_packet_t [`N-1:0]               cdb,
    input  logic        [`NUM_FU_ALU-1:0]      alu_avail,
    input  logic        [`NUM_FU_MULT-1:0]     mult_avail,
    output fu_packet_t  [`NUM_FU_ALU-1:0]      alu_packet,
    output fu_packet_t  [`NUM_FU_MULT-1:0]     mult_packet,
    output logic                               almost_full
);

    rs_entry_t [`RS_SZ-1:0] entries;
    rs_entry_t [`RS_SZ-1:0] next_entries;
    logic [`RS_CNT_WIDTH-1:0] counter;
    logic [`RS_CNT_WIDTH-1:0] next_counter;

    logic [`RS_SZ-1:0] ready;
    logic [`RS_SZ-1:0] alu_req;
    logic [`RS_SZ-1:0] mult_req;
    logic [`RS_SZ-1:0] taken;      // slots filled this cycle
    logic [`RS_SZ-1:0] issue_mask; // slots leaving this cycle

    logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0]  alu_gnt_bus;
    logic [`NUM_FU_MULT-1:0][`RS_SZ-1:0] mult_gnt_bus;
    logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0]  alu_sel;
    logic [`NUM_FU_MULT-1:0][`RS_SZ-1:0] mult_sel;

    // snoop both CDB slots for either operand tag
    function automatic rs_entry_t wake(input rs_entry_t e, input cdb_packet_t [`N-1:0] bus);
        rs_entry_t w;
        w = e;
        for (int c = 0; c < `N; c++) begin
            if (bus[c].valid && !w.op1_ready && w.op1.tag.prn == bus[c].dest_prn) begin
                w.op1.value = bus[c].value;
                w.op1_ready = 1'b1;
            end
            if (bus[c].valid && !w.op2_ready && w.op2.tag.prn == bus[c].dest_prn) begin
                w.op2.value = bus[c].value;
                w.op2_ready = 1'b1;
            end
        end
        return w;
    endfunction

    function automatic fu_packet_t to_packet(input rs_entry_t e);
        return '{valid: 1'b1, func: e.func, op1: e.op1.value, op2: e.op2.value,
                 dest_prn: e.dest_prn, robn: e.robn};
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            ready[i]    = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready;
            alu_req[i]  = ready[i] && entries[i].fu == FU_ALU;
            mult_req[i] = ready[i] && entries[i].fu == FU_MULT;
        end
    end

    rs_select #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_ALU)) alu_select (
        .req(alu_req),
        .gnt_bus(alu_gnt_bus)
    );

    rs_select #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_MULT)) mult_select (
        .req(mult_req),
        .gnt_bus(mult_gnt_bus)
    );

    // a grant to a busy unit is simply not taken
    always_comb begin
        issue_mask = '0;
        for (int j = 0; j < `NUM_FU_ALU; j++) begin
            alu_sel[j] = alu_gnt_bus[j] & {`RS_SZ{alu_avail[j]}};
            issue_mask = issue_mask | alu_sel[j];
            alu_packet[j] = '0;
            for (int i = 0; i < `RS_SZ; i++) begin
                if (alu_sel[j][i]) alu_packet[j] = to_packet(entries[i]);
            end
        end
        for (int j = 0; j < `NUM_FU_MULT; j++) begin
            mult_sel[j] = mult_gnt_bus[j] & {`RS_SZ{mult_avail[j]}};
            issue_mask = issue_mask | mult_sel[j];
            mult_packet[j] = '0;
            for (int i = 0; i < `RS_SZ; i++) begin
                if (mult_sel[j][i]) mult_packet[j] = to_packet(entries[i]);
            end
        end
    end

    always_comb begin
        logic placed;
        taken = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            next_entries[i] = wake(entries[i], cdb);
            if (issue_mask[i]) next_entries[i].valid = 1'b0;
        end
        // new entries go to slots that are free right now
        for (int k = 0; k < `N; k++) begin
            placed = 1'b0;
            for (int i = 0; i < `RS_SZ; i++) begin
                if (entries_in[k].valid && !almost_full && !placed
                        && !entries[i].valid && !taken[i]) begin
                    next_entries[i] = wake(entries_in[k], cdb);
                    taken[i] = 1'b1;
                    placed = 1'b1;
                end
            end
        end
        next_counter = counter + `RS_CNT_WIDTH'($countones(taken))
                               - `RS_CNT_WIDTH'($countones(issue_mask));
    end

    assign almost_full = counter > (`RS_SZ - `N);

    always_ff @(posedge clock) begin
        if (reset) begin
            counter <= '0;
            for (int i = 0; i < `RS_SZ; i++) begin
                entries[i].valid <= 1'b0; // payload left as is
            end
        end else begin
            counter <= next_counter;
            entries <= next_entries;
        end
    end

    assert property (@(posedge clock) disable iff (reset) counter <= `RS_SZ);

    // upstream must hold dispatch while the stall is up
    assert property (@(posedge clock) disable iff (reset)
        almost_full |-> !(entries_in[0].valid || entries_in[`N-1].valid));

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module alu_unit import isa_pkg::*, ooo_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  fu_packet_t  issue,
    input  logic        grant,
    output cdb_packet_t result,
    output logic        avail
);

    logic [`XLEN-1:0] alu_out;
    logic             res_valid;
    logic [`PRN_WIDTH-1:0]  res_prn;
    logic [`XLEN-1:0]       res_value;
    logic [`ROBN_WIDTH-1:0] res_robn;

    always_comb begin
        case (issue.func)
            ALU_ADD: alu_out = issue.op1 + issue.op2;
            ALU_SUB: alu_out = issue.op1 - issue.op2;
            ALU_AND: alu_out = issue.op1 & issue.op2;
            ALU_OR:  alu_out = issue.op1 | issue.op2;
            ALU_XOR: alu_out = issue.op1 ^ issue.op2;
            ALU_SLL: alu_out = issue.op1 << issue.op2[4:0];
            ALU_SRL: alu_out = issue.op1 >> issue.op2[4:0];
            ALU_SLT: alu_out = {31'b0, $signed(issue.op1) < $signed(issue.op2)};
            default: alu_out = '0;
        endcase
    end

    // free when empty or draining onto the CDB
    assign avail = !res_valid || grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (issue.valid) begin
            res_valid <= 1'b1;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            res_prn   <= issue.dest_prn;
            res_value <= alu_out;
            res_robn  <= issue.robn;
        end
    end

    assign result = '{valid: res_valid, dest_prn: res_prn, value: res_value, robn: res_robn};

    // the station must not overwrite a result still waiting for the CDB
    assert property (@(posedge clock) disable iff (reset) issue.valid |-> avail);

endmodule

//--- hdl/mult_unit.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module mult_unit import ooo_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  fu_packet_t  issue,
    output cdb_packet_t result
);

    logic s1_valid;
    logic s2_valid;
    logic [`XLEN-1:0]       s1_pp_lo;  // op1 times low half of op2
    logic [15:0]            s1_pp_hi;  // only the low half survives the shift
    logic [`PRN_WIDTH-1:0]  s1_prn, s2_prn;
    logic [`ROBN_WIDTH-1:0] s1_robn, s2_robn;
    logic [`XLEN-1:0]       s2_value;

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_pp_lo <= issue.op1 * issue.op2[15:0];
        s1_pp_hi <= issue.op1[15:0] * issue.op2[31:16];
        s1_prn   <= issue.dest_prn;
        s1_robn  <= issue.robn;
        s2_value <= s1_pp_lo + {s1_pp_hi, 16'b0}; // low word of the product
        s2_prn   <= s1_prn;
        s2_robn  <= s1_robn;
    end

    assign result = '{valid: s2_valid, dest_prn: s2_prn, value: s2_value, robn: s2_robn};

endmodule

//--- hdl/cdb_result.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module cdb_result import ooo_pkg::*; (
    input  cdb_packet_t [`NUM_FU_MULT-1:0] mult_result,
    input  cdb_packet_t [`NUM_FU_ALU-1:0]  alu_results,
    output cdb_packet_t [`N-1:0]           cdb,
    output logic        [`NUM_FU_ALU-1:0]  alu_grant
);

    always_comb begin
        int slot;
        slot      = 0;
        cdb       = '0;
        alu_grant = '0;
        // multiplier first since it has nowhere to hold a result
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            if (mult_result[m].valid && slot < `N) begin
                cdb[slot] = mult_result[m];
                slot++;
            end
        end
        for (int a = 0; a < `NUM_FU_ALU; a++) begin
            if (alu_results[a].valid && slot < `N) begin
                cdb[slot]    = alu_results[a];
                alu_grant[a] = 1'b1;
                slot++;
            end
        end
    end

    // every multiplier result leaves on some CDB slot in the same cycle
    always_comb begin
        logic found;
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            found = 1'b0;
            for (int s = 0; s < `N; s++) begin
                if (cdb[s] == mult_result[m]) found = 1'b1;
            end
            assert final (!mult_result[m].valid || found);
        end
    end

endmodule

//--- hdl/issue_exec_top.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module issue_exec_top import ooo_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  dispatch_slot_t [`N-1:0]     dispatch,
    output logic                        dispatch_stall,
    output cdb_packet_t    [`N-1:0]     cdb
);

    rs_entry_t   [`N-1:0]           entries;
    fu_packet_t  [`NUM_FU_ALU-1:0]  alu_packet;
    fu_packet_t  [`NUM_FU_MULT-1:0] mult_packet;
    cdb_packet_t [`NUM_FU_ALU-1:0]  alu_result;
    cdb_packet_t [`NUM_FU_MULT-1:0] mult_result;
    logic        [`NUM_FU_ALU-1:0]  alu_avail;
    logic        [`NUM_FU_MULT-1:0] mult_avail;
    logic        [`NUM_FU_ALU-1:0]  alu_grant;

    assign mult_avail = '1; // pipelined, never busy

    inst_decode inst_decode_inst (
        .slots(dispatch),
        .entries(entries)
    );

    rs rs_inst (
        .clock(clock),
        .reset(reset),
        .entries_in(entries),
        .cdb(cdb),
        .alu_avail(alu_avail),
        .mult_avail(mult_avail),
        .alu_packet(alu_packet),
        .mult_packet(mult_packet),
        .almost_full(dispatch_stall)
    );

    for (genvar a = 0; a < `NUM_FU_ALU; a++) begin : g_alu
        alu_unit alu_unit_inst (
            .clock(clock),
            .reset(reset),
            .issue(alu_packet[a]),
            .grant(alu_grant[a]),
            .result(alu_result[a]),
            .avail(alu_avail[a])
        );
    end

    for (genvar m = 0; m < `NUM_FU_MULT; m++) begin : g_mult
        mult_unit mult_unit_inst (
            .clock(clock),
            .reset(reset),
            .issue(mult_packet[m]),
            .result(mult_result[m])
        );
    end

    cdb_result cdb_result_inst (
        .mult_result(mult_result),
        .alu_results(alu_result),
        .cdb(cdb),
        .alu_grant(alu_grant)
    );

endmodule

//--- tb/issue_exec_tb.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module issue_exec_tb import isa_pkg::*, ooo_pkg::*; ();

    localparam int PERIOD      = 40;
    localparam int TEST_CYCLES = 14 * 12 + 30 + 30 + 40 + 30; // summed test lengths

    logic                    clock;
    logic                    reset;
    dispatch_slot_t [`N-1:0] dispatch;
    logic                    dispatch_stall;
    cdb_packet_t    [`N-1:0] cdb;

    int          errors = 0;
    int          cycle = 0;
    int          pending = 0;
    logic [31:0] lfsr = 32'h711b_e78f;

    // scoreboard indexed by robn
    logic        exp_valid [32];
    logic [5:0]  exp_prn [32];
    logic [31:0] exp_value [32];
    int          exp_lat [32];    // -1 when contention makes it unknown
    int          disp_cycle [32];
    int          dep [32];        // producer robn or -1
    logic        done [32];
    int          done_cycle [32];

    issue_exec_top issue_exec_top_inst (
        .clock(clock),
        .reset(reset),
        .dispatch(dispatch),
        .dispatch_stall(dispatch_stall),
        .cdb(cdb)
    );

    initial clock = 1'b0;
    always #(PERIOD / 2) clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    // taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] r_type_inst(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_inst(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, 7'b0010011};
    endfunction

    // reference model straight from the RV32IM rules
    function automatic logic [31:0] model(input logic [31:0] inst, input logic [31:0] a,
                                          input logic [31:0] b);
        logic        is_imm;
        logic [31:0] y;
        is_imm = inst[6:0] == 7'b0010011;
        y = is_imm ? {{20{inst[31]}}, inst[31:20]} : b;
        if (!is_imm && inst[31:25] == 7'b0000001) return a * y;
        case (inst[14:12])
            3'd0:    return (!is_imm && inst[30]) ? a - y : a + y;
            3'd1:    return a << y[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(y)};
            3'd4:    return a ^ y;
            3'd5:    return a >> y[4:0];
            3'd6:    return a | y;
            default: return a & y;
        endcase
    endfunction

    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic clear_board();
        for (int r = 0; r < 32; r++) begin
            exp_valid[r] = 1'b0;
            done[r] = 1'b0;
            dep[r] = -1;
        end
        pending = 0;
    endtask

    task automatic load_slot(input int k, input logic [31:0] inst, input logic r1,
                             input logic [31:0] s1, input logic r2, input logic [31:0] s2,
                             input logic [5:0] prn, input logic [4:0] robn);
        dispatch[k].valid = 1'b1;
        dispatch[k].inst = inst;
        dispatch[k].src1_ready = r1;
        dispatch[k].src1.value = s1;
        dispatch[k].src2_ready = r2;
        dispatch[k].src2.value = s2;
        dispatch[k].dest_prn = prn;
        dispatch[k].robn = robn;
    endtask

    task automatic expect_result(input logic [4:0] robn, input logic [5:0] prn,
                                 input logic [31:0] value, input int lat, input int producer);
        exp_valid[robn] = 1'b1;
        exp_prn[robn] = prn;
        exp_value[robn] = value;
        exp_lat[robn] = lat;
        disp_cycle[robn] = cycle;
        dep[robn] = producer;
        pending++;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (pending > 0 && n < limit) begin
            step();
            n++;
        end
        assert (pending == 0) else begin
            errors++;
            $display("%0d results still missing after %0d cycles", pending, limit);
        end
    endtask

    task automatic check_quiet();
        assert (!cdb[0].valid && !cdb[`N-1].valid) else begin
            errors++;
            $display("[ERROR] cdb valid %h %h expected 0 0", cdb[0].valid, cdb[`N-1].valid);
        end
        assert (!dispatch_stall) else begin
            errors++;
            $display("[ERROR] dispatch_stall %h expected 0", dispatch_stall);
        end
    endtask

    // one result checker for every test
    always @(negedge clock) begin
        int r;
        if (!reset) begin
            for (int s = 0; s < `N; s++) begin
                if (cdb[s].valid) begin
                    r = cdb[s].robn;
                    assert (exp_valid[r]) else begin
                        errors++;
                        $display("unexpected or repeated CDB result for robn %0d", r);
                    end
                    if (exp_valid[r]) begin
                        assert (cdb[s].dest_prn == exp_prn[r]) else begin
                            errors++;
                            $display("[ERROR] cdb.dest_prn robn %0d got %h expected %h",
                                     r, cdb[s].dest_prn, exp_prn[r]);
                        end
                        assert (cdb[s].value == exp_value[r]) else begin
                            errors++;
                            $display("[ERROR] cdb.value robn %0d got %h expected %h",
                                     r, cdb[s].value, exp_value[r]);
                        end
                        assert (exp_lat[r] < 0 || cycle - disp_cycle[r] == exp_lat[r]) else begin
                            errors++;
                            $display("result for robn %0d took %0d cycles instead of %0d",
                                     r, cycle - disp_cycle[r], exp_lat[r]);
                        end
                        assert (dep[r] < 0 || (done[dep[r]] && done_cycle[dep[r]] < cycle))
                        else begin
                            errors++;
                            $display("robn %0d broadcast before its producer", r);
                        end
                        exp_valid[r] = 1'b0;
                        done[r] = 1'b1;
                        done_cycle[r] = cycle;
                        pending--;
                    end
                end
            end
        end
    end

    task automatic each_op_results();
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        clear_board();
        for (int op = 0; op < 14; op++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            case (op)
                0:  inst = r_type_inst(7'h00, 3'd0);
                1:  inst = r_type_inst(7'h20, 3'd0);
                2:  inst = r_type_inst(7'h00, 3'd7);
                3:  inst = r_type_inst(7'h00, 3'd6);
                4:  inst = r_type_inst(7'h00, 3'd4);
                5:  inst = r_type_inst(7'h00, 3'd1);
                6:  inst = r_type_inst(7'h00, 3'd5);
                7:  inst = r_type_inst(7'h00, 3'd2);
                8:  inst = r_type_inst(7'h01, 3'd0); // mul
                9:  inst = i_type_inst(rand_bits(12), 3'd0);
                10: inst = i_type_inst(rand_bits(12), 3'd7);
                11: inst = i_type_inst(rand_bits(12), 3'd6);
                12: inst = i_type_inst(rand_bits(12), 3'd4);
                default: inst = i_type_inst(rand_bits(12), 3'd2);
            endcase
            step();
            load_slot(0, inst, 1'b1, a, 1'b1, b, 6'(op + 1), 5'(op));
            expect_result(5'(op), 6'(op + 1), model(inst, a, b), (op == 8) ? 3 : 2, -1);
            step();
            dispatch = '0;
            wait_idle(10);
        end
    endtask

    task automatic dependency_chain();
        logic [31:0] inst [4];
        logic [31:0] b [4];
        logic [31:0] val;
        logic [31:0] a0;
        logic [31:0] b0;
        clear_board();
        inst[0] = r_type_inst(7'h00, 3'd4);
        inst[1] = r_type_inst(7'h01, 3'd0);
        inst[2] = i_type_inst(rand_bits(12), 3'd0);
        inst[3] = r_type_inst(7'h20, 3'd0);
        a0 = rand_bits(32);
        b0 = rand_bits(32);
        val = a0 + b0;
        for (int i = 0; i < 4; i++) b[i] = rand_bits(32);
        step();
        load_slot(0, r_type_inst(7'h00, 3'd0), 1'b1, a0, 1'b1, b0, 6'd10, 5'd0);
        load_slot(1, inst[0], 1'b0, 32'd10, 1'b1, b[0], 6'd11, 5'd1);
        expect_result(5'd0, 6'd10, val, 2, -1);
        val = model(inst[0], val, b[0]);
        expect_result(5'd1, 6'd11, val, -1, 0);
        step();
        load_slot(0, inst[1], 1'b0, 32'd11, 1'b1, b[1], 6'd12, 5'd2);
        load_slot(1, inst[2], 1'b0, 32'd12, 1'b1, b[2], 6'd13, 5'd3);
        val = model(inst[1], val, b[1]);
        expect_result(5'd2, 6'd12, val, -1, 1);
        val = model(inst[2], val, b[2]);
        expect_result(5'd3, 6'd13, val, -1, 2);
        step();
        load_slot(0, inst[3], 1'b0, 32'd13, 1'b1, b[3], 6'd14, 5'd4);
        dispatch[1] = '0;
        expect_result(5'd4, 6'd14, model(inst[3], val, b[3]), -1, 3);
        step();
        dispatch = '0;
        wait_idle(30);
    endtask

    task automatic unit_contention();
        logic [31:0] a [4];
        logic [31:0] b [4];
        logic [31:0] inst [4];
        clear_board();
        inst[0] = r_type_inst(7'h01, 3'd0);
        inst[1] = r_type_inst(7'h01, 3'd0);
        inst[2] = r_type_inst(7'h00, 3'd6);
        inst[3] = i_type_inst(rand_bits(12), 3'd4);
        for (int i = 0; i < 4; i++) begin
            a[i] = rand_bits(32);
            b[i] = rand_bits(32);
        end
        for (int p = 0; p < 2; p++) begin
            step();
            for (int k = 0; k < 2; k++) begin
                load_slot(k, inst[2*p+k], 1'b1, a[2*p+k], 1'b1, b[2*p+k],
                          6'(20 + 2*p + k), 5'(8 + 2*p + k));
                expect_result(5'(8 + 2*p + k), 6'(20 + 2*p + k),
                              model(inst[2*p+k], a[2*p+k], b[2*p+k]), -1, -1);
            end
        end
        step();
        dispatch = '0;
        wait_idle(30);
    endtask

    task automatic fill_and_drain();
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] mval;
        logic [31:0] inst;
        logic [31:0] b;
        clear_board();
        ma = rand_bits(32);
        mb = rand_bits(32);
        mval = ma * mb;
        for (int e = 0; e < 7; e++) begin
            if (e % 2 == 0) step();
            inst = (e % 3 == 0) ? r_type_inst(7'h00, 3'd4) : r_type_inst(7'h20, 3'd0);
            b = rand_bits(32);
            load_slot(e % 2, inst, 1'b0, 32'd40, 1'b1, b, 6'(41 + e), 5'(e));
            expect_result(5'(e), 6'(41 + e), model(inst, mval, b), -1, 20);
            if (e == 5) begin
                step();
                dispatch = '0;
                assert (!dispatch_stall) else begin
                    errors++;
                    $display("[ERROR] dispatch_stall %h expected 0 at 6 entries", dispatch_stall);
                end
            end
        end
        // producer of tag 40 joins the last waiting entry
        load_slot(1, r_type_inst(7'h01, 3'd0), 1'b1, ma, 1'b1, mb, 6'd40, 5'd20);
        expect_result(5'd20, 6'd40, mval, 3, -1);
        step();
        dispatch = '0;
        assert (dispatch_stall) else begin
            errors++;
            $display("[ERROR] dispatch_stall %h expected 1 at 8 entries", dispatch_stall);
        end
        wait_idle(30);
        step();
        assert (!dispatch_stall) else begin
            errors++;
            $display("[ERROR] dispatch_stall %h expected 0 after drain", dispatch_stall);
        end
    endtask

    task automatic reset_recovery();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] inst;
        clear_board();
        // seven entries park on tag 50 and a ready multiply joins the last pair
        for (int p = 0; p < 4; p++) begin
            step();
            for (int k = 0; k < 2; k++) begin
                if (p == 3 && k == 1) begin
                    load_slot(k, r_type_inst(7'h01, 3'd0), 1'b1, rand_bits(32), 1'b1,
                              rand_bits(32), 6'd60, 5'd9);
                end else begin
                    load_slot(k, r_type_inst(7'h00, 3'd0), 1'b0, 32'd50, 1'b1,
                              rand_bits(32), 6'(51 + 2*p + k), 5'(2*p + k));
                end
            end
        end
        step();
        dispatch = '0;
        step(); // multiply now in its first stage
        assert (dispatch_stall) else begin
            errors++;
            $display("[ERROR] dispatch_stall %h expected 1 before reset", dispatch_stall);
        end
        reset = 1'b1;
        for (int i = 0; i < 4; i++) begin
            step();
            check_quiet();
        end
        reset = 1'b0;
        for (int i = 0; i < 2; i++) begin
            step();
            check_quiet();
        end
        a = rand_bits(32);
        b = rand_bits(32);
        inst = r_type_inst(7'h00, 3'd7);
        load_slot(0, inst, 1'b1, a, 1'b1, b, 6'd50, 5'd10);
        expect_result(5'd10, 6'd50, model(inst, a, b), 2, -1);
        step();
        dispatch = '0;
        wait_idle(10);
        // entries that outlived the reset would wake on tag 50 and broadcast here
        repeat (4) step();
    endtask

    initial begin
        #(TEST_CYCLES * 4 * PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        dispatch = '0;
        clear_board();
        repeat (4) step();
        reset = 1'b0;
        each_op_results();
        dependency_chain();
        unit_contention();
        fill_and_drain();
        reset_recovery();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/ooo_pkg.sv
hdl/inst_decode.sv
hdl/rs_select.sv
hdl/rs.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/cdb_result.sv
hdl/issue_exec_top.sv
tb/issue_exec_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = issue_exec_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors
FAIL_MSG  = Errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
